// File: all.f
+incdir+test
hw/ifu_pkg.sv
hw/ifu_pc_gen.sv
hw/ifu_axi_master.sv
hw/ifu_bpu.sv
hw/ifu_pipe.sv
hw/ifu.sv
test/axi_rom_model.sv
test/tb_ifu.sv

// File: hw/ifu.sv
// Instruction fetch unit top level.
// Merges control unit jumps with predicted redirects, derives the stalls and
// connects the PC generator, AXI read master, predictor and decode register.
// A jump is expected to come with a flush when wrong-path words must be killed.

`timescale 1ns/100ps

module ifu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                jump_flag_i,     // one-cycle jump pulse
    input  ifu_pkg::inst_addr_t jump_addr_i,
    input  ifu_pkg::cu_bus_t    stall_flag_i,
    input  logic                update_valid_i,  // execute stage training
    input  ifu_pkg::inst_addr_t update_pc_i,
    input  logic                real_taken_i,
    output ifu_pkg::inst_data_t inst_o,
    output ifu_pkg::inst_addr_t inst_addr_o,
    output logic                is_pred_branch_o,
    output logic                inst_valid_o,
    output logic                read_resp_error_o,
    output ifu_pkg::ar_chan_t   ar_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  ifu_pkg::r_chan_t    r_i,
    input  logic                rvalid_i,
    output logic                rready_o
);

    ifu_pkg::inst_addr_t pc;
    logic                pc_misaligned;
    logic                pc_stall;       // read in flight
    logic                ar_fire;
    ifu_pkg::fetch_t     axi_fetch;      // word from the bus
    logic                axi_inst_valid;
    logic                branch_taken;
    ifu_pkg::inst_addr_t branch_addr;
    logic                is_pred_branch;
    ifu_pkg::fetch_t     pipe_in;
    ifu_pkg::fetch_t     pipe_out;
    logic                redirect;
    ifu_pkg::inst_addr_t redirect_addr;
    logic                stall_if;
    logic                flush;
    logic                stall_axi;
    logic                stall_pc;

    assign redirect      = jump_flag_i | branch_taken;
    assign redirect_addr = jump_flag_i ? jump_addr_i : branch_addr;  // control unit wins

    assign stall_if  = stall_flag_i[ifu_pkg::CU_STALL_IF];
    assign flush     = stall_flag_i[ifu_pkg::CU_FLUSH];
    assign stall_axi = stall_if | flush | pc_misaligned;
    assign stall_pc  = stall_axi | pc_stall;

    ifu_pc_gen u_ifu_pc_gen (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .redirect_i      (redirect),
        .redirect_addr_i (redirect_addr),
        .stall_pc_i      (stall_pc),
        .ar_fire_i       (ar_fire),
        .pc_o            (pc),
        .pc_misaligned_o (pc_misaligned)
    );

    ifu_axi_master u_ifu_axi_master (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .pc_i              (pc),
        .stall_axi_i       (stall_axi),
        .redirect_i        (redirect),
        .ar_o              (ar_o),
        .arvalid_o         (arvalid_o),
        .arready_i         (arready_i),
        .r_i               (r_i),
        .rvalid_i          (rvalid_i),
        .rready_o          (rready_o),
        .fetch_o           (axi_fetch),
        .inst_valid_o      (axi_inst_valid),
        .read_resp_error_o (read_resp_error_o),
        .pc_stall_o        (pc_stall),
        .ar_fire_o         (ar_fire)
    );

    ifu_bpu u_ifu_bpu (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .inst_i           (axi_fetch.inst),
        .pc_i             (axi_fetch.inst_addr),
        .inst_valid_i     (axi_inst_valid),
        .update_valid_i   (update_valid_i),
        .update_pc_i      (update_pc_i),
        .real_taken_i     (real_taken_i),
        .branch_taken_o   (branch_taken),
        .branch_addr_o    (branch_addr),
        .is_pred_branch_o (is_pred_branch)
    );

    // prediction flag joins the record on its way to decode
    assign pipe_in = '{
        inst:           axi_fetch.inst,
        inst_addr:      axi_fetch.inst_addr,
        is_pred_branch: is_pred_branch
    };

    ifu_pipe u_ifu_pipe (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .fetch_i      (pipe_in),
        .inst_valid_i (axi_inst_valid),
        .stall_i      (stall_if),
        .flush_i      (flush),
        .fetch_o      (pipe_out),
        .inst_valid_o (inst_valid_o)
    );

    assign inst_o           = pipe_out.inst;
    assign inst_addr_o      = pipe_out.inst_addr;
    assign is_pred_branch_o = pipe_out.is_pred_branch;

endmodule

// File: hw/ifu_axi_master.sv
// Single outstanding AXI4 read master for instruction fetch.
// Issues one single-beat read per PC, tags it with that PC and returns the word
// as a one-cycle inst_valid pulse. Beats that belong to a PC left behind by a
// redirect are dropped, and a bad response turns into read_resp_error_o.

`timescale 1ns/100ps

module ifu_axi_master (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ifu_pkg::inst_addr_t pc_i,         // pc to fetch next
    input  logic                stall_axi_i,  // no new read
    input  logic                redirect_i,   // pc is being replaced
    output ifu_pkg::ar_chan_t   ar_o,
    output logic                arvalid_o,
    input  logic                arready_i,
    input  ifu_pkg::r_chan_t    r_i,
    input  logic                rvalid_i,
    output logic                rready_o,
    output ifu_pkg::fetch_t     fetch_o,
    output logic                inst_valid_o,       // word delivered
    output logic                read_resp_error_o,  // bad response pulse
    output logic                pc_stall_o,         // read in flight
    output logic                ar_fire_o           // AR handshake
);

    ifu_pkg::axi_state_e state_q;
    ifu_pkg::axi_state_e state_d;
    ifu_pkg::inst_addr_t addr_q;   // pc tag of the read in flight
    logic                drop_q;   // beat belongs to a stale pc
    logic                drop_d;
    logic                issue;    // leave IDLE this cycle
    logic                ar_hs;    // AR handshake
    logic                r_fire;
    logic                resp_bad;

    assign arvalid_o  = (state_q == ifu_pkg::ADDR);
    assign ar_hs      = arvalid_o & arready_i;
    assign pc_stall_o = (state_q == ifu_pkg::DATA);

    // a read already marked stale must not step the pc
    // the redirect target that replaced it is fetched next
    assign ar_fire_o = ar_hs & ~drop_q;

    // a good beat waits while decode is stalled so no word is lost
    // a stale beat is taken at once
    assign rready_o = (state_q == ifu_pkg::DATA) & (drop_q | ~stall_axi_i);
    assign r_fire   = rvalid_i & rready_o;

    // pc_i may change at the next edge under redirect so do not sample it then
    assign issue = (state_q == ifu_pkg::IDLE) & ~stall_axi_i & ~redirect_i;

    always_comb begin
        state_d = state_q;
        drop_d  = drop_q;
        case (state_q)
            ifu_pkg::IDLE: begin
                drop_d = 1'b0;
                if (issue) begin
                    state_d = ifu_pkg::ADDR;
                end
            end
            ifu_pkg::ADDR: begin
                // arvalid must stay up so a redirect only marks the beat stale
                // a handshake under stall leaves the pc unstepped so refetch it
                if (redirect_i || (ar_hs && stall_axi_i)) begin
                    drop_d = 1'b1;
                end
                if (ar_hs) begin
                    state_d = ifu_pkg::DATA;
                end
            end
            ifu_pkg::DATA: begin
                if (r_fire) begin
                    state_d = ifu_pkg::IDLE;  // done with this pc
                    drop_d  = 1'b0;
                end else if (redirect_i) begin
                    drop_d = 1'b1;  // discard when it arrives
                end
            end
            default: begin
                state_d = ifu_pkg::IDLE;
                drop_d  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ifu_pkg::IDLE;
            drop_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            drop_q  <= drop_d;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            addr_q <= pc_i;  // also the tag of the returned word
        end
    end

    assign ar_o = '{
        araddr:  addr_q,
        arid:    ifu_pkg::FETCH_ID,
        arlen:   ifu_pkg::AXI_LEN_SINGLE,
        arsize:  ifu_pkg::AXI_SIZE_WORD,
        arburst: ifu_pkg::AXI_BURST_INCR,
        arcache: ifu_pkg::AXI_CACHE_NORM,
        arprot:  ifu_pkg::AXI_PROT_INST
    };

    // slave error or a beat that is not our single-beat read
    assign resp_bad = (r_i.rresp != ifu_pkg::AXI_RESP_OKAY) |
                      (r_i.rid != ifu_pkg::FETCH_ID) | ~r_i.rlast;

    // a beat completing in a redirect cycle still counts
    assign inst_valid_o      = r_fire & ~drop_q & ~resp_bad;
    assign read_resp_error_o = r_fire & ~drop_q & resp_bad;

    assign fetch_o = '{
        inst:           r_i.rdata,
        inst_addr:      addr_q,
        is_pred_branch: 1'b0  // filled in by the top level
    };

endmodule

// File: hw/ifu_bpu.sv
// Branch predictor for the fetch stage.
// Decodes JAL and B-type words from the returning beat in the same cycle.
// JAL is always taken and a branch follows its 2-bit history counter.
// The execute stage trains the counters with update_valid_i.

`timescale 1ns/100ps

module ifu_bpu (
    input  logic                clk,
    input  logic                rst_n_i,
    input  ifu_pkg::inst_data_t inst_i,
    input  ifu_pkg::inst_addr_t pc_i,            // address of inst_i
    input  logic                inst_valid_i,
    input  logic                update_valid_i,  // training strobe
    input  ifu_pkg::inst_addr_t update_pc_i,     // branch being trained
    input  logic                real_taken_i,    // resolved direction
    output logic                branch_taken_o,
    output ifu_pkg::inst_addr_t branch_addr_o,
    output logic                is_pred_branch_o
);

    ifu_pkg::bht_cnt_t             bht_q [ifu_pkg::BHT_DEPTH];
    logic [ifu_pkg::BHT_IDX_W-1:0] rd_idx;
    logic [ifu_pkg::BHT_IDX_W-1:0] upd_idx;
    ifu_pkg::bht_cnt_t             rd_cnt;
    ifu_pkg::bht_cnt_t             upd_cnt;
    logic                          is_jal;
    logic                          is_branch;
    ifu_pkg::inst_addr_t           imm_j;
    ifu_pkg::inst_addr_t           imm_b;

    assign is_jal    = (inst_i[6:0] == ifu_pkg::OPC_JAL);
    assign is_branch = (inst_i[6:0] == ifu_pkg::OPC_BRANCH);

    // J-type immediate in bit order 20 19:12 11 10:1
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    // B-type immediate in bit order 12 11 10:5 4:1
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

    assign rd_idx  = pc_i[ifu_pkg::BHT_IDX_W+1:2];  // word index
    assign upd_idx = update_pc_i[ifu_pkg::BHT_IDX_W+1:2];
    assign rd_cnt  = bht_q[rd_idx];
    assign upd_cnt = bht_q[upd_idx];

    // counter 2 or 3 predicts taken
    assign branch_taken_o   = inst_valid_i & (is_jal | (is_branch & rd_cnt[1]));
    assign branch_addr_o    = pc_i + (is_jal ? imm_j : imm_b);
    assign is_pred_branch_o = branch_taken_o;  // decode sees the redirect it caused

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < ifu_pkg::BHT_DEPTH; i++) begin
                bht_q[i] <= ifu_pkg::BHT_INIT;
            end
        end else if (update_valid_i) begin
            if (real_taken_i) begin
                if (upd_cnt != 2'b11) begin
                    bht_q[upd_idx] <= upd_cnt + 2'b01;  // toward taken
                end
            end else begin
                if (upd_cnt != 2'b00) begin
                    bht_q[upd_idx] <= upd_cnt - 2'b01;  // toward not taken
                end
            end
        end
    end

endmodule

// File: hw/ifu_pc_gen.sv
// Fetch program counter.
// Loads redirect targets, steps by one word per accepted AR and holds under stall.
// Flags a misaligned PC so the AXI master stops issuing until an aligned redirect.

`timescale 1ns/100ps

module ifu_pc_gen (
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                redirect_i,       // jump or predicted taken
    input  ifu_pkg::inst_addr_t redirect_addr_i,  // target of the redirect
    input  logic                stall_pc_i,       // hold request
    input  logic                ar_fire_i,        // AR handshake this cycle
    output ifu_pkg::inst_addr_t pc_o,
    output logic                pc_misaligned_o
);

    ifu_pkg::inst_addr_t pc_q;
    ifu_pkg::inst_addr_t pc_d;
    logic                step;

    // the current pc was accepted on the bus and nothing holds it
    assign step = ar_fire_i & ~stall_pc_i;

    always_comb begin
        pc_d = pc_q;  // default hold
        if (redirect_i) begin
            pc_d = redirect_addr_i;  // redirect beats step and stall
        end else if (step) begin
            pc_d = pc_q + ifu_pkg::PC_STEP;  // next sequential word
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= ifu_pkg::RESET_PC;
        end else begin
            pc_q <= pc_d;
        end
    end

    assign pc_o = pc_q;

    // only a redirect can produce this
    // a step from an aligned pc stays aligned
    assign pc_misaligned_o = |pc_q[1:0];

endmodule

// File: hw/ifu_pipe.sv
// Fetch to decode pipeline register.
// Captures each delivered word one cycle after the beat, holds under stall
// and drops the valid bit on flush.

`timescale 1ns/100ps

module ifu_pipe (
    input  logic            clk,
    input  logic            rst_n_i,
    input  ifu_pkg::fetch_t fetch_i,
    input  logic            inst_valid_i,
    input  logic            stall_i,       // IF stall level
    input  logic            flush_i,       // flush pulse
    output ifu_pkg::fetch_t fetch_o,
    output logic            inst_valid_o
);

    ifu_pkg::inst_data_t inst_q;
    ifu_pkg::inst_addr_t addr_q;
    logic                pred_q;
    logic                valid_q;

    // control bits
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            pred_q  <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // flush wins over stall
            pred_q  <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= inst_valid_i;
            pred_q  <= fetch_i.is_pred_branch & inst_valid_i;
        end
    end

    // payload follows the valid bit
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            inst_q <= fetch_i.inst;
            addr_q <= fetch_i.inst_addr;
        end
    end

    assign fetch_o = '{inst: inst_q, inst_addr: addr_q, is_pred_branch: pred_q};
    assign inst_valid_o = valid_q;

endmodule

// File: hw/ifu_pkg.sv
// Shared types and constants of the instruction fetch unit.
// Every fetch block refers to these by scoped name (ifu_pkg::name).
// Covers address and data widths, the AXI read channel records and the decode handoff.

package ifu_pkg;

    typedef logic [31:0] inst_addr_t;  // byte address of an instruction
    typedef logic [31:0] inst_data_t;  // raw RV32I instruction word
    typedef logic [3:0]  bus_id_t;     // axi transaction id
    typedef logic [1:0]  bht_cnt_t;    // 2-bit saturating counter
    typedef logic [1:0]  cu_bus_t;     // stall/flush bus from control unit

    localparam int CU_STALL_IF = 0;  // fetch stall level
    localparam int CU_FLUSH    = 1;  // flush pulse

    localparam int       BHT_DEPTH = 64;     // history entries
    localparam int       BHT_IDX_W = 6;      // indexed by pc[7:2]
    localparam bht_cnt_t BHT_INIT  = 2'b01;  // weakly not taken

    localparam inst_addr_t RESET_PC = 32'h0000_0000;
    localparam inst_addr_t PC_STEP  = 32'd4;  // no compressed instructions

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // fixed AR attributes for a single word fetch
    localparam bus_id_t    FETCH_ID       = 4'h1;
    localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;     // one beat
    localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;   // 4 bytes
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [3:0] AXI_CACHE_NORM = 4'b0010;  // normal non-cacheable
    localparam logic [2:0] AXI_PROT_INST  = 3'b100;   // instruction access
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

    typedef struct packed {
        inst_addr_t araddr;
        bus_id_t    arid;
        logic [7:0] arlen;
        logic [2:0] arsize;
        logic [1:0] arburst;
        logic [3:0] arcache;
        logic [2:0] arprot;
    } ar_chan_t;

    typedef struct packed {
        bus_id_t    rid;
        inst_data_t rdata;
        logic [1:0] rresp;
        logic       rlast;
    } r_chan_t;

    // record handed from fetch to decode
    typedef struct packed {
        inst_data_t inst;
        inst_addr_t inst_addr;
        logic       is_pred_branch;  // predicted taken jal or branch
    } fetch_t;

    typedef enum logic [1:0] {
        IDLE = 2'd0,  // waiting to issue
        ADDR = 2'd1,  // arvalid up
        DATA = 2'd2   // waiting for the r beat
    } axi_state_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# Build the fetch unit testbench with Verilator, run it and check the log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module tb_ifu -o tb_ifu \
    && ./obj_dir/tb_ifu | tee sim.log \
    || { echo "build or simulation failed"; exit 1; }

grep -q "ERRORS FOUND" sim.log && exit 1 || exit 0

// File: test/rom_image.svh
// Instruction image shared by the AXI ROM model and the testbench.
// Included inside a module body. One JAL and one backward branch are placed,
// every other word is an addi whose immediate comes from the address.

localparam logic [31:0] JAL_PC  = 32'h0000_0040;
localparam logic [31:0] JAL_TGT = 32'h0000_0080;  // forward by 0x40
localparam logic [31:0] BR_PC   = 32'h0000_0090;
localparam logic [31:0] BR_TGT  = 32'h0000_0080;  // back by 0x10

function automatic logic [31:0] rom_word(input logic [31:0] addr);
    logic [31:0] off;
    logic [31:0] word;
    off = 32'd0;
    if (addr == JAL_PC) begin
        off  = JAL_TGT - JAL_PC;
        word = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};  // jal x1
    end else if (addr == BR_PC) begin
        off  = BR_TGT - BR_PC;
        // beq x0, x0
        word = {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    end else begin
        word = {addr[13:2] ^ addr[25:14] ^ {6'd0, addr[31:26]}, 5'd0, 3'b000, 5'd2,
                7'b0010011};  // addi x2, x0, imm
    end
    return word;
endfunction

// File: test/axi_rom_model.sv
// AXI read slave for the fetch unit testbench.
// Answers single-beat reads from the computed image after a random 0 to 4 cycle
// delay, with random arready gaps. err_en_i turns the beat for err_addr_i into SLVERR.

`timescale 1ns/100ps

module axi_rom_model (
    input  logic              clk,
    input  logic              rst_n_i,
    input  ifu_pkg::ar_chan_t ar_i,
    input  logic              arvalid_i,
    output logic              arready_o,
    output ifu_pkg::r_chan_t  r_o,
    output logic              rvalid_o,
    input  logic              rready_i,
    input  logic              err_en_i,
    input  logic [31:0]       err_addr_i
);

    `include "rom_image.svh"

    int          seed;
    int          wait_cnt;  // cycles left before the beat
    logic        pending;   // request accepted, beat not yet up
    logic        ar_hs;
    logic        r_hs;
    logic [31:0] req_addr;

    initial begin
        seed      = 32'h0b19_c893;
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        r_o       = '0;
        pending   = 1'b0;
        wait_cnt  = 0;
        req_addr  = '0;
        forever begin
            @(posedge clk);
            ar_hs = arvalid_i & arready_o;  // values before the edge
            r_hs  = rvalid_o & rready_i;
            if (ar_hs) begin
                req_addr = ar_i.araddr;
            end
            @(negedge clk);
            if (!rst_n_i) begin
                arready_o = 1'b0;
                rvalid_o  = 1'b0;
                pending   = 1'b0;
            end else begin
                if (r_hs) begin
                    rvalid_o = 1'b0;
                end
                if (ar_hs) begin
                    pending  = 1'b1;
                    wait_cnt = $unsigned($random(seed)) % 5;
                end
                if (pending) begin
                    if (wait_cnt == 0) begin
                        r_o = '{rid:   ifu_pkg::FETCH_ID,
                                rdata: rom_word(req_addr),
                                rresp: (err_en_i && req_addr == err_addr_i) ? 2'b10
                                                                            : ifu_pkg::AXI_RESP_OKAY,
                                rlast: 1'b1};
                        rvalid_o = 1'b1;
                        pending  = 1'b0;
                    end else begin
                        wait_cnt = wait_cnt - 1;
                    end
                end
                // one request at a time, about one cycle in four without arready
                arready_o = !pending && !rvalid_o && ($random(seed) % 4 != 0);
            end
        end
    end

endmodule

// File: test/tb_ifu.sv
// Testbench for the fetch unit.
// Walks sequential fetch, JAL, trained branch, jumps, misaligned jump, stall,
// flush and an error response. A reference model of the fetch stream and the
// history table checks every word that reaches decode.

`timescale 1ns/100ps

module tb_ifu;

    `include "rom_image.svh"

    localparam int CLK_PERIOD   = 20;
    localparam int MAX_FETCHES  = 200;  // all tests together, with slack
    localparam int WORST_CYCLES = 12;   // issue, arready gaps, latency 4
    localparam int TIMEOUT_NS   = MAX_FETCHES * WORST_CYCLES * CLK_PERIOD + 4000;

    logic                clk;
    logic                rst_n;
    logic                jump_flag;
    logic [31:0]         jump_addr;
    ifu_pkg::cu_bus_t    stall_flag;
    logic                update_valid;
    logic [31:0]         update_pc;
    logic                real_taken;
    logic [31:0]         inst;
    logic [31:0]         inst_addr;
    logic                is_pred_branch;
    logic                inst_valid;
    logic                read_resp_error;
    ifu_pkg::ar_chan_t   ar;
    logic                arvalid;
    logic                arready;
    ifu_pkg::r_chan_t    r;
    logic                rvalid;
    logic                rready;
    logic                err_en;
    logic [31:0]         err_addr;

    logic [1:0]  bht_ref [64];  // mirror of the history table
    logic [31:0] exp_addr;      // next address decode should see
    int          n_err;
    int          n_checks;
    int          resp_errs;

    ifu u_dut (
        .clk               (clk),
        .rst_n_i           (rst_n),
        .jump_flag_i       (jump_flag),
        .jump_addr_i       (jump_addr),
        .stall_flag_i      (stall_flag),
        .update_valid_i    (update_valid),
        .update_pc_i       (update_pc),
        .real_taken_i      (real_taken),
        .inst_o            (inst),
        .inst_addr_o       (inst_addr),
        .is_pred_branch_o  (is_pred_branch),
        .inst_valid_o      (inst_valid),
        .read_resp_error_o (read_resp_error),
        .ar_o              (ar),
        .arvalid_o         (arvalid),
        .arready_i         (arready),
        .r_i               (r),
        .rvalid_i          (rvalid),
        .rready_o          (rready)
    );

    axi_rom_model u_rom (
        .clk        (clk),
        .rst_n_i    (rst_n),
        .ar_i       (ar),
        .arvalid_i  (arvalid),
        .arready_o  (arready),
        .r_o        (r),
        .rvalid_o   (rvalid),
        .rready_i   (rready),
        .err_en_i   (err_en),
        .err_addr_i (err_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // jal always, the branch when its counter is 2 or 3
    function automatic logic predicted(input logic [31:0] a);
        return (a == JAL_PC) || (a == BR_PC && bht_ref[a[7:2]] >= 2'd2);
    endfunction

    function automatic logic [31:0] next_fetch(input logic [31:0] a);
        if (a == JAL_PC) begin
            return JAL_TGT;
        end
        if (predicted(a)) begin
            return BR_TGT;
        end
        return a + 32'd4;
    endfunction

    task automatic jump_flush(input logic [31:0] a);
        @(negedge clk);
        jump_flag  = 1'b1;
        jump_addr  = a;
        stall_flag = 2'b10;  // flush kills the wrong path
        @(negedge clk);
        jump_flag  = 1'b0;
        stall_flag = 2'b00;
    endtask

    task automatic wait_addr(input logic [31:0] a);
        do @(negedge clk); while (!(inst_valid && inst_addr == a));
    endtask

    // trains under IF stall so no word lands during the update
    task automatic train_taken(input logic [31:0] pc, input int n);
        @(negedge clk);
        stall_flag = 2'b01;
        repeat (2) @(negedge clk);
        for (int k = 0; k < n; k++) begin
            update_valid = 1'b1;
            update_pc    = pc;
            real_taken   = 1'b1;
            @(negedge clk);
        end
        update_valid = 1'b0;
        real_taken   = 1'b0;
        @(negedge clk);
        stall_flag = 2'b00;
    endtask

    // compare process
    initial begin : compare
        logic        held;
        logic        flushed;
        logic        quiet;
        logic        stall_prev;
        logic        arv_prev;
        logic        ar_wait;       // arvalid up without arready
        logic [31:0] ar_addr_prev;
        logic        v_prev;
        logic [31:0] i_prev;
        logic [31:0] a_prev;
        logic [5:0]  idx;
        stall_prev   = 1'b0;
        arv_prev     = 1'b0;
        ar_wait      = 1'b0;
        ar_addr_prev = '0;
        v_prev       = 1'b0;
        i_prev       = '0;
        a_prev       = '0;
        forever begin
            @(posedge clk);
            held    = stall_flag[ifu_pkg::CU_STALL_IF] & ~stall_flag[ifu_pkg::CU_FLUSH];
            flushed = stall_flag[ifu_pkg::CU_FLUSH];
            quiet   = stall_prev | (exp_addr[1:0] != 2'b00);
            assert (!(rst_n && quiet && arvalid && !arv_prev)) else begin
                n_err++;
                $display("** Error at %0t: new AR raised while stalled or misaligned", $time);
            end
            // single aligned word, instruction access
            if (rst_n && arvalid && arready) begin
                assert (ar.arid == ifu_pkg::FETCH_ID && ar.arlen == 8'd0 &&
                        ar.arsize == 3'b010 && ar.araddr[1:0] == 2'b00 && ar.arprot[2])
                else begin
                    n_err++;
                    $display("** Error at %0t: AR %h is not a single word fetch", $time, ar);
                end
            end
            assert (!ar_wait || (arvalid && ar.araddr == ar_addr_prev)) else begin
                n_err++;
                $display("** Error at %0t: AR payload changed before arready", $time);
            end
            ar_wait      = rst_n & arvalid & ~arready;
            ar_addr_prev = ar.araddr;
            arv_prev     = arvalid;
            stall_prev   = stall_flag[ifu_pkg::CU_STALL_IF];
            if (read_resp_error) begin
                resp_errs++;
                assert (exp_addr == err_addr) else begin
                    n_err++;
                    $display("** Error at %0t: error response for %h, expected %h",
                             $time, exp_addr, err_addr);
                end
                exp_addr = exp_addr + 32'd4;  // word is skipped
            end
            if (update_valid) begin
                idx = update_pc[7:2];
                if (real_taken && bht_ref[idx] != 2'd3) begin
                    bht_ref[idx] = bht_ref[idx] + 2'd1;
                end else if (!real_taken && bht_ref[idx] != 2'd0) begin
                    bht_ref[idx] = bht_ref[idx] - 2'd1;
                end
            end
            if (jump_flag) begin
                exp_addr = jump_addr;
            end
            @(negedge clk);
            if (rst_n) begin
                if (flushed) begin
                    assert (!inst_valid) else begin
                        n_err++;
                        $display("** Error at %0t: inst_valid_o set after flush", $time);
                    end
                end else if (held) begin
                    assert (inst_valid == v_prev && inst == i_prev && inst_addr == a_prev)
                    else begin
                        n_err++;
                        $display("** Error at %0t: outputs changed under stall", $time);
                    end
                end else if (inst_valid) begin
                    n_checks++;
                    assert (inst_addr == exp_addr && inst == rom_word(exp_addr) &&
                            is_pred_branch == predicted(exp_addr)) else begin
                        n_err++;
                        $display("** Error at %0t: got %h/%h/%b expected %h/%h/%b", $time,
                                 inst_addr, inst, is_pred_branch, exp_addr,
                                 rom_word(exp_addr), predicted(exp_addr));
                    end
                    exp_addr = next_fetch(inst_addr);
                end
            end
            v_prev = inst_valid;
            i_prev = inst;
            a_prev = inst_addr;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests completed");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        rst_n        = 1'b0;
        jump_flag    = 1'b0;
        jump_addr    = '0;
        stall_flag   = 2'b00;
        update_valid = 1'b0;
        update_pc    = '0;
        real_taken   = 1'b0;
        err_en       = 1'b0;
        err_addr     = 32'h0000_050c;
        exp_addr     = ifu_pkg::RESET_PC;
        n_err        = 0;
        n_checks     = 0;
        resp_errs    = 0;
        for (int i = 0; i < 64; i++) begin
            bht_ref[i] = 2'd1;  // weakly not taken
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        assert (!arvalid && !rready && !inst_valid && !is_pred_branch && !read_resp_error)
        else begin
            n_err++;
            $display("** Error at %0t: outputs not idle during reset", $time);
        end
        rst_n = 1'b1;
        // sequential run into the jal
        wait_addr(JAL_TGT);
        // branch falls through first, then trained and taken
        wait_addr(BR_PC + 32'd4);
        train_taken(BR_PC, 2);
        jump_flush(BR_TGT);
        wait_addr(BR_PC);
        wait_addr(BR_TGT);
        // jump while a read is in flight
        do @(posedge clk); while (!(arvalid && arready));
        jump_flush(32'h0000_0200);
        wait_addr(32'h0000_0204);
        // misaligned target stops fetch until an aligned jump
        jump_flush(32'h0000_0302);
        repeat (20) @(negedge clk);
        jump_flush(32'h0000_0300);
        wait_addr(32'h0000_0308);
        // stall holds the valid word at 0x308
        stall_flag = 2'b01;
        repeat (8) @(negedge clk);
        // flush beats the stall and the jump target follows
        jump_flag  = 1'b1;
        jump_addr  = 32'h0000_0400;
        stall_flag = 2'b11;
        @(negedge clk);
        jump_flag  = 1'b0;
        stall_flag = 2'b00;
        wait_addr(32'h0000_0404);
        // error response on one word
        err_en = 1'b1;
        jump_flush(32'h0000_0500);
        wait_addr(32'h0000_0514);
        assert (resp_errs == 1) else begin
            n_err++;
            $display("** Error at %0t: %0d error responses seen, expected 1", $time, resp_errs);
        end
        repeat (5) @(negedge clk);
        $display("checked %0d words, %0d errors", n_checks, n_err);
        if (n_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
